// File: src/opx_config.svh
`ifndef OPX_CONFIG_SVH
`define OPX_CONFIG_SVH

////////////////////
// Datapath sizing
////////////////////

// Width of every operand, immediate and result word
`define OPX_WIDTH 32

// Architectural registers in the file
// Register 0 reads as zero and is never written
`define OPX_NREGS 16

// Bits needed to name one register
// Must satisfy 2**OPX_RADDR_W >= OPX_NREGS
`define OPX_RADDR_W 4

////////////////////
// Derived values
////////////////////

// ALU opcode width, eight operations
`define OPX_OP_W 3

`endif

// File: src/opx_pkg.sv
`include "opx_config.svh"

package opx_pkg;

	////////////////////
	// Width types
	////////////////////

	// One data word
	typedef logic [`OPX_WIDTH-1:0] word_t;

	// One register number
	typedef logic [`OPX_RADDR_W-1:0] reg_addr_t;

	////////////////////
	// Encodings
	////////////////////

	// ALU operations
	// Shifts use the low bits of operand B
	typedef enum logic [`OPX_OP_W-1:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_or   = 3'd3,
		op_xor  = 3'd4,
		op_sll  = 3'd5,
		op_srl  = 3'd6,
		op_movb = 3'd7
	} alu_op_t;

	// Operand source select
	// Same code points as the classic operand mux
	typedef enum logic [1:0] {
		sel_rf  = 2'd0,
		sel_imm = 2'd1,
		sel_ex  = 2'd2,
		sel_wb  = 2'd3
	} opnd_sel_t;

	////////////////////
	// Stage bundles
	////////////////////

	// Decoded instruction from fetch
	// imm is already sign-extended
	typedef struct packed {
		logic      valid;
		alu_op_t   op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		logic      use_imm;
		word_t     imm;
	} id_instr_t;

	// Execute stage control
	typedef struct packed {
		logic      valid;
		alu_op_t   op;
		reg_addr_t rd;
	} ex_ctrl_t;

	// Write-back port, also the register file write port
	typedef struct packed {
		logic      we;
		reg_addr_t rd;
		word_t     data;
	} wb_t;

endpackage

// File: src/opx_regfile.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  opx_pkg::reg_addr_t ra,
	input  opx_pkg::reg_addr_t rb,
	input  opx_pkg::wb_t       wb,
	output opx_pkg::word_t     rf_dataa,
	output opx_pkg::word_t     rf_datab
);

	// Register storage
	// Entry 0 exists but is only ever cleared
	opx_pkg::word_t regs [`OPX_NREGS];

	////////////////////
	// Write port
	////////////////////

	// Whole file cleared on reset
	// Single write per edge from write-back
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `OPX_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.rd] <= wb.data;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Asynchronous reads
	// Register 0 is hard zero
	// A same-cycle write is not visible here, forwarding covers it
	assign rf_dataa = (ra == '0) ? '0 : regs[ra];
	assign rf_datab = (rb == '0) ? '0 : regs[rb];

	////////////////////
	// Checks
	////////////////////

	// The write strobe comes from the write-back stage
	// It must already exclude register 0
	a_no_r0_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb.we |-> (wb.rd != '0)
	) else $error("opx_regfile: write strobe aimed at register 0");

endmodule

// File: src/opx_fwd_select.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_fwd_select (
	input  opx_pkg::id_instr_t id_instr,
	input  opx_pkg::ex_ctrl_t  ex_ctrl,
	input  opx_pkg::wb_t       wb,
	output opx_pkg::opnd_sel_t sel_a,
	output opx_pkg::opnd_sel_t sel_b
);

	// Stage holds a live result worth forwarding
	logic ex_live;
	logic wb_live;

	// Per-operand source matches
	logic ex_hit_a;
	logic ex_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	// Register 0 never forwards
	assign ex_live = ex_ctrl.valid && (ex_ctrl.rd != '0);
	assign wb_live = wb.we && (wb.rd != '0);

	assign ex_hit_a = ex_live && (id_instr.ra == ex_ctrl.rd);
	assign ex_hit_b = ex_live && (id_instr.rb == ex_ctrl.rd);
	assign wb_hit_a = wb_live && (id_instr.ra == wb.rd);
	assign wb_hit_b = wb_live && (id_instr.rb == wb.rd);

	// Operand A takes the youngest producer first
	always_comb begin
		if (ex_hit_a)
			sel_a = opx_pkg::sel_ex;
		else if (wb_hit_a)
			sel_a = opx_pkg::sel_wb;
		else
			sel_a = opx_pkg::sel_rf;
	end

	// Operand B lets the immediate override any register hazard
	always_comb begin
		if (id_instr.use_imm)
			sel_b = opx_pkg::sel_imm;
		else if (ex_hit_b)
			sel_b = opx_pkg::sel_ex;
		else if (wb_hit_b)
			sel_b = opx_pkg::sel_wb;
		else
			sel_b = opx_pkg::sel_rf;
	end

endmodule

// File: src/opx_operand_mux.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_operand_mux (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               id_freeze,
	input  logic               ex_freeze,
	input  opx_pkg::word_t     rf_dataa,
	input  opx_pkg::word_t     rf_datab,
	input  opx_pkg::word_t     ex_forw,
	input  opx_pkg::word_t     wb_forw,
	input  opx_pkg::word_t     simm,
	input  opx_pkg::opnd_sel_t sel_a,
	input  opx_pkg::opnd_sel_t sel_b,
	output opx_pkg::word_t     operand_a,
	output opx_pkg::word_t     operand_b
);

	// Index 0 is operand A
	// Index 1 is operand B
	opx_pkg::word_t muxed [2];
	opx_pkg::word_t opnd_q [2];
	logic           saved [2];

	////////////////////
	// Source muxes
	////////////////////

	// Operand A has no immediate path
	always_comb begin
		case (sel_a)
			opx_pkg::sel_rf:  muxed[0] = rf_dataa;
			opx_pkg::sel_imm: muxed[0] = rf_dataa;
			opx_pkg::sel_ex:  muxed[0] = ex_forw;
			opx_pkg::sel_wb:  muxed[0] = wb_forw;
			default:          muxed[0] = rf_dataa;
		endcase
	end

	// Operand B
	always_comb begin
		case (sel_b)
			opx_pkg::sel_rf:  muxed[1] = rf_datab;
			opx_pkg::sel_imm: muxed[1] = simm;
			opx_pkg::sel_ex:  muxed[1] = ex_forw;
			opx_pkg::sel_wb:  muxed[1] = wb_forw;
			default:          muxed[1] = rf_datab;
		endcase
	end

	////////////////////
	// Operand registers
	////////////////////

	// First decode stall cycle captures and marks the value saved
	// Later stall cycles keep it because forwarding sources have moved on
	// Normal flow captures every edge
	// Saved flag drops on the edge the held instruction enters execute
	for (genvar i = 0; i < 2; i++) begin : g_opnd
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				opnd_q[i] <= '0;
				saved[i]  <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved[i]) begin
				opnd_q[i] <= muxed[i];
				saved[i]  <= 1'b1;
			end else if (!ex_freeze && !saved[i]) begin
				opnd_q[i] <= muxed[i];
			end else if (!ex_freeze && !id_freeze) begin
				saved[i] <= 1'b0;
			end
		end
	end

	assign operand_a = opnd_q[0];
	assign operand_b = opnd_q[1];

endmodule

// File: src/opx_alu.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_alu (
	input  opx_pkg::alu_op_t op,
	input  opx_pkg::word_t   a,
	input  opx_pkg::word_t   b,
	output opx_pkg::word_t   result
);

	// Shift amount width, 5 bits for a 32-bit word
	localparam int shamt_w = $clog2(`OPX_WIDTH);

	logic [shamt_w-1:0] shamt;

	// Upper bits of B are ignored by shifts
	assign shamt = b[shamt_w-1:0];

	////////////////////
	// Operation select
	////////////////////

	always_comb begin
		case (op)
			// Arithmetic wraps at word width
			opx_pkg::op_add:
				result = a + b;
			opx_pkg::op_sub:
				result = a - b;
			// Bitwise logic
			opx_pkg::op_and:
				result = a & b;
			opx_pkg::op_or:
				result = a | b;
			opx_pkg::op_xor:
				result = a ^ b;
			// Logical shifts, zero fill
			opx_pkg::op_sll:
				result = a << shamt;
			opx_pkg::op_srl:
				result = a >> shamt;
			// Move, used for load-immediate
			opx_pkg::op_movb:
				result = b;
			default:
				result = '0;
		endcase
	end

endmodule

// File: src/opx_exwb_stage.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_exwb_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               id_freeze,
	input  logic               ex_freeze,
	input  opx_pkg::id_instr_t id_instr,
	input  opx_pkg::word_t     ex_result,
	output opx_pkg::ex_ctrl_t  ex_ctrl,
	output opx_pkg::wb_t       wb
);

	// Write-back register contents
	logic               wb_valid;
	opx_pkg::reg_addr_t wb_rd;
	opx_pkg::word_t     wb_data;

	////////////////////
	// Execute control
	////////////////////

	// Decode moving means accept
	// Decode stalled alone means bubble
	// Full stall holds
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!id_freeze) begin
			ex_ctrl.valid <= id_instr.valid;
			ex_ctrl.op    <= id_instr.op;
			ex_ctrl.rd    <= id_instr.rd;
		end else if (!ex_freeze) begin
			ex_ctrl.valid <= 1'b0;
		end
	end

	////////////////////
	// Write-back register
	////////////////////

	// Valid bit follows execute whenever execute advances
	always_ff @(posedge clk) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else if (!ex_freeze)
			wb_valid <= ex_ctrl.valid;
	end

	// Payload, qualified by wb_valid
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_rd   <= ex_ctrl.rd;
			wb_data <= ex_result;
		end
	end

	// Strobe lasts one cycle per instruction
	// Register file commits on the edge that ends it
	always_comb begin
		wb.we   = wb_valid && (wb_rd != '0) && !ex_freeze;
		wb.rd   = wb_rd;
		wb.data = wb_data;
	end

	// Freeze levels are nested
	a_freeze_nest: assert property (
		@(posedge clk) disable iff (!rst_n)
		ex_freeze |-> id_freeze
	) else $error("opx_exwb_stage: ex_freeze raised without id_freeze");

endmodule

// File: src/opx_top.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               id_freeze,
	input  logic               ex_freeze,
	input  opx_pkg::id_instr_t id_instr,
	output opx_pkg::wb_t       wb
);

	// Decode stage values
	opx_pkg::word_t     rf_dataa;
	opx_pkg::word_t     rf_datab;
	opx_pkg::opnd_sel_t sel_a;
	opx_pkg::opnd_sel_t sel_b;

	// Execute stage values
	opx_pkg::word_t     operand_a;
	opx_pkg::word_t     operand_b;
	opx_pkg::word_t     ex_result;
	opx_pkg::ex_ctrl_t  ex_ctrl;

	// Register file, written from write-back
	opx_regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.ra       (id_instr.ra),
		.rb       (id_instr.rb),
		.wb       (wb),
		.rf_dataa (rf_dataa),
		.rf_datab (rf_datab)
	);

	// Hazard detection
	opx_fwd_select u_fwd_select (
		.id_instr (id_instr),
		.ex_ctrl  (ex_ctrl),
		.wb       (wb),
		.sel_a    (sel_a),
		.sel_b    (sel_b)
	);

	// Operand muxes and operand registers
	opx_operand_mux u_operand_mux (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_result),
		.wb_forw   (wb.data),
		.simm      (id_instr.imm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	opx_alu u_alu (
		.op     (ex_ctrl.op),
		.a      (operand_a),
		.b      (operand_b),
		.result (ex_result)
	);

	// Execute control and write-back
	opx_exwb_stage u_exwb_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_instr  (id_instr),
		.ex_result (ex_result),
		.ex_ctrl   (ex_ctrl),
		.wb        (wb)
	);

endmodule

// File: tests/opx_tb.sv
`timescale 1ns/100ps
`include "opx_config.svh"

module opx_tb;

	localparam int clk_period = 40;
	localparam int n_instr = 400;
	localparam int drain_cycles = 8;
	// At most five cycles per instruction with margin for reset and drain
	localparam int wd_cycles = n_instr * 6 + 20;

	logic               clk;
	logic               rst_n;
	logic               id_freeze;
	logic               ex_freeze;
	opx_pkg::id_instr_t id_instr;
	opx_pkg::wb_t       wb;

	// Architectural state and expected retirements
	opx_pkg::word_t arch_regs [`OPX_NREGS];
	opx_pkg::wb_t   exp_q [$];
	logic [31:0]    lcg_state;
	int             burst_left;
	int             accepted;
	int             exp_writes;
	int             retired;
	int             mismatch_errs;
	int             other_errs;

	opx_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_instr  (id_instr),
		.wb        (wb)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	// LCG step returning the better upper half
	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Mostly registers 0 to 3 so that hazards are frequent
	function automatic opx_pkg::reg_addr_t pick_reg();
		logic [15:0] r;
		r = next_random();
		if (r[3:0] < 4'd11)
			return opx_pkg::reg_addr_t'(r[5:4]);
		return opx_pkg::reg_addr_t'(r[9:6]);
	endfunction

	function automatic opx_pkg::id_instr_t random_instr();
		opx_pkg::id_instr_t ins;
		logic [15:0] r;
		logic [15:0] imm16;
		r = next_random();
		imm16 = next_random();
		ins.valid   = 1'b1;
		ins.op      = opx_pkg::alu_op_t'(r[2:0]);
		ins.use_imm = r[3];
		ins.rd      = pick_reg();
		ins.ra      = pick_reg();
		ins.rb      = pick_reg();
		// Sign extension done by fetch
		ins.imm     = {{16{imm16[15]}}, imm16};
		return ins;
	endfunction

	// Bursts of 1 to 4 frozen cycles with a free cycle after each
	// ex_freeze only ever raised together with id_freeze
	task automatic drive_freezes();
		logic [15:0] r;
		r = next_random();
		if (burst_left > 0) begin
			id_freeze = 1'b1;
			ex_freeze = r[0];
			burst_left--;
		end else begin
			id_freeze = 1'b0;
			ex_freeze = 1'b0;
			if (r[3:1] < 3'd3)
				burst_left = 1 + r[5:4];
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	function automatic opx_pkg::word_t model_op(opx_pkg::alu_op_t op,
			opx_pkg::word_t a, opx_pkg::word_t b);
		case (op)
			opx_pkg::op_add:  return a + b;
			opx_pkg::op_sub:  return a + ~b + 32'd1;
			opx_pkg::op_and:  return a & b;
			opx_pkg::op_or:   return a | b;
			opx_pkg::op_xor:  return a ^ b;
			opx_pkg::op_sll:  return a << b[4:0];
			opx_pkg::op_srl:  return a >> b[4:0];
			default:          return b;
		endcase
	endfunction

	// Program order execution that never writes register 0
	task automatic model_accept(opx_pkg::id_instr_t ins);
		opx_pkg::word_t a;
		opx_pkg::word_t b;
		opx_pkg::wb_t   w;
		a = arch_regs[ins.ra];
		b = ins.use_imm ? ins.imm : arch_regs[ins.rb];
		w.we   = 1'b1;
		w.rd   = ins.rd;
		w.data = model_op(ins.op, a, b);
		accepted++;
		if (ins.rd != '0) begin
			arch_regs[ins.rd] = w.data;
			exp_q.push_back(w);
			exp_writes++;
		end
	endtask

	// Write-back port as it stood through the cycle ending at this edge
	task automatic check_writeback();
		opx_pkg::wb_t exp;
		if (wb.we === 1'b1) begin
			assert (exp_q.size() > 0) else begin
				$display("Write-back to register %0d at %0t with nothing outstanding",
					wb.rd, $time);
				other_errs++;
			end
			if (exp_q.size() > 0) begin
				exp = exp_q.pop_front();
				retired++;
				assert (wb.rd === exp.rd) else begin
					$display("Mismatch at %0t: wb.rd = %0d, expected %0d",
						$time, wb.rd, exp.rd);
					mismatch_errs++;
				end
				assert (wb.data === exp.data) else begin
					$display("Mismatch at %0t: wb.data = %h, expected %h",
						$time, wb.data, exp.data);
					mismatch_errs++;
				end
			end
		end else begin
			assert (wb.we === 1'b0) else begin
				$display("Mismatch at %0t: wb.we = %b, expected 0 or 1", $time, wb.we);
				mismatch_errs++;
			end
		end
	endtask

	task automatic print_counts();
		$display("Summary: %0d accepted, %0d/%0d retired, %0d mismatches, %0d other errors",
			accepted, retired, exp_writes, mismatch_errs, other_errs);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin : main
		opx_pkg::id_instr_t cur;
		rst_n = 1'b0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		id_instr = '0;
		lcg_state = 32'h696;
		burst_left = 0;
		accepted = 0;
		exp_writes = 0;
		retired = 0;
		mismatch_errs = 0;
		other_errs = 0;
		for (int i = 0; i < `OPX_NREGS; i++)
			arch_regs[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Idle cycles with no instruction able to retire
		repeat (3) begin
			@(posedge clk);
			assert (wb.we === 1'b0) else begin
				$display("Mismatch at %0t: wb.we = %b, expected 0", $time, wb.we);
				mismatch_errs++;
			end
		end
		cur = random_instr();
		while (accepted < n_instr) begin
			@(negedge clk);
			drive_freezes();
			id_instr = cur;
			@(posedge clk);
			check_writeback();
			// Accepted on an edge with decode moving
			if (!id_freeze) begin
				model_accept(cur);
				cur = random_instr();
			end
		end
		// Drain with bubbles
		repeat (drain_cycles) begin
			@(negedge clk);
			id_freeze = 1'b0;
			ex_freeze = 1'b0;
			id_instr = '0;
			@(posedge clk);
			check_writeback();
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d expected writes never retired", exp_q.size());
			other_errs++;
		end
		print_counts();
		if (mismatch_errs == 0 && other_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(wd_cycles * clk_period);
		$display("Watchdog expired, the run did not end within %0d cycles", wd_cycles);
		other_errs++;
		print_counts();
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: opx.f
+incdir+src
src/opx_pkg.sv
src/opx_regfile.sv
src/opx_fwd_select.sv
src/opx_operand_mux.sv
src/opx_alu.sv
src/opx_exwb_stage.sv
src/opx_top.sv
tests/opx_tb.sv
